/* logic/flag_pkg.sv */
`default_nettype none

package flag_pkg;

  localparam int FLAG_WIDTH = 6;  // CF, PF, AF, ZF, SF and OF

  // Bit positions inside a raw flag word
  localparam int CF_BIT = 0;
  localparam int PF_BIT = 1;
  localparam int AF_BIT = 2;
  localparam int ZF_BIT = 3;
  localparam int SF_BIT = 4;
  localparam int OF_BIT = 5;

  typedef union packed {
    logic [FLAG_WIDTH-1:0] raw;  // Storage and mask merge view
    struct packed {
      logic of;
      logic sf;
      logic zf;
      logic af;
      logic pf;
      logic cf;
    } f;  // Named view for condition evaluation
  } flags_u;

  localparam int COND_WIDTH = 4;  // Low nibble of a Jcc opcode

  // An odd code is the negation of the even code below it
  localparam logic [COND_WIDTH-1:0] COND_O  = 4'd0;
  localparam logic [COND_WIDTH-1:0] COND_NO = 4'd1;
  localparam logic [COND_WIDTH-1:0] COND_B  = 4'd2;
  localparam logic [COND_WIDTH-1:0] COND_AE = 4'd3;
  localparam logic [COND_WIDTH-1:0] COND_E  = 4'd4;
  localparam logic [COND_WIDTH-1:0] COND_NE = 4'd5;
  localparam logic [COND_WIDTH-1:0] COND_BE = 4'd6;
  localparam logic [COND_WIDTH-1:0] COND_A  = 4'd7;
  localparam logic [COND_WIDTH-1:0] COND_S  = 4'd8;
  localparam logic [COND_WIDTH-1:0] COND_NS = 4'd9;
  localparam logic [COND_WIDTH-1:0] COND_P  = 4'd10;
  localparam logic [COND_WIDTH-1:0] COND_NP = 4'd11;
  localparam logic [COND_WIDTH-1:0] COND_L  = 4'd12;
  localparam logic [COND_WIDTH-1:0] COND_GE = 4'd13;
  localparam logic [COND_WIDTH-1:0] COND_LE = 4'd14;
  localparam logic [COND_WIDTH-1:0] COND_G  = 4'd15;

endpackage

`default_nettype wire

/* logic/flag_write_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module flag_write_decode
  import flag_pkg::*;
#(
  parameter int ENTRIES = 8,
  localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
)
(
  input  logic                                  wr0_en,
  input  logic [IDX_W-1:0]                      wr0_index,
  input  logic [FLAG_WIDTH-1:0]                 wr0_flags,
  input  logic [FLAG_WIDTH-1:0]                 wr0_mask,
  input  logic                                  wr1_en,
  input  logic [IDX_W-1:0]                      wr1_index,
  input  logic [FLAG_WIDTH-1:0]                 wr1_flags,
  input  logic [FLAG_WIDTH-1:0]                 wr1_mask,
  output logic [ENTRIES-1:0][FLAG_WIDTH-1:0]    cell_wdata,
  output logic [ENTRIES-1:0][FLAG_WIDTH-1:0]    cell_wmask
);

  // Each entry sees the masks of the ports that address it this cycle
  for (genvar e = 0; e < ENTRIES; e++)
  begin : g_entry
    logic                  hit0;
    logic                  hit1;
    logic [FLAG_WIDTH-1:0] mask0;
    logic [FLAG_WIDTH-1:0] mask1;

    assign hit0 = wr0_en && (wr0_index == IDX_W'(e));  // Port 0 targets this entry
    assign hit1 = wr1_en && (wr1_index == IDX_W'(e));  // Port 1 targets this entry

    assign mask0 = hit0 ? wr0_mask : '0;
    assign mask1 = hit1 ? wr1_mask : '0;

    // An overlap still writes every flag that either port requests
    assign cell_wmask[e] = mask0 | mask1;

    // Port 1 supplies every flag it masks and port 0 fills in the rest
    assign cell_wdata[e] = (mask1 & wr1_flags) | (~mask1 & wr0_flags);
  end

endmodule

`default_nettype wire

/* logic/flag_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module flag_cell
  import flag_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [FLAG_WIDTH-1:0] wdata,
  input  logic [FLAG_WIDTH-1:0] wmask,
  output flags_u                flags,
  output logic                  written
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flags.raw <= '0;
      written   <= 1'b0;
    end
    else
    begin
      flags.raw <= (flags.raw & ~wmask) | (wdata & wmask);  // Unmasked flags keep their value
      if (|wmask)
      begin
        written <= 1'b1;  // Sticky until the next reset
      end
    end
  end

endmodule

`default_nettype wire

/* logic/flag_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module flag_read_port
  import flag_pkg::*;
#(
  parameter int ENTRIES = 8,
  localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
)
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    read_clk_en,
  input  logic [IDX_W-1:0]        read_index,
  input  logic [COND_WIDTH-1:0]   read_cond,
  input  flags_u [ENTRIES-1:0]    cell_flags,
  input  logic [ENTRIES-1:0]      cell_written,
  output flags_u                  read_flags,
  output logic                    read_written,
  output logic                    read_cond_true
);

  logic [IDX_W-1:0]      index_q;  // Entry held between captures
  logic [COND_WIDTH-1:0] cond_q;   // Condition held between captures
  flags_u                sel;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      index_q <= '0;
      cond_q  <= COND_O;
    end
    else if (read_clk_en)
    begin
      index_q <= read_index;
      cond_q  <= read_cond;
    end
  end

  // Storage is read live, so later writes to the held entry show through
  assign sel          = cell_flags[index_q];
  assign read_flags   = sel;
  assign read_written = cell_written[index_q];

  always_comb
  begin
    case (cond_q)
      COND_O:  read_cond_true = sel.f.of;
      COND_NO: read_cond_true = !sel.f.of;
      COND_B:  read_cond_true = sel.f.cf;
      COND_AE: read_cond_true = !sel.f.cf;
      COND_E:  read_cond_true = sel.f.zf;
      COND_NE: read_cond_true = !sel.f.zf;
      COND_BE: read_cond_true = sel.f.cf | sel.f.zf;  // Unsigned below or equal
      COND_A:  read_cond_true = !(sel.f.cf | sel.f.zf);
      COND_S:  read_cond_true = sel.f.sf;
      COND_NS: read_cond_true = !sel.f.sf;
      COND_P:  read_cond_true = sel.f.pf;
      COND_NP: read_cond_true = !sel.f.pf;
      COND_L:  read_cond_true = sel.f.sf ^ sel.f.of;  // Signed less than
      COND_GE: read_cond_true = !(sel.f.sf ^ sel.f.of);
      COND_LE: read_cond_true = sel.f.zf | (sel.f.sf ^ sel.f.of);
      COND_G:  read_cond_true = !(sel.f.zf | (sel.f.sf ^ sel.f.of));
      default: read_cond_true = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/flag_file.sv */
`timescale 1ns/1ps
`default_nettype none

module flag_file
  import flag_pkg::*;
#(
  parameter int ENTRIES = 8,
  localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr0_en,
  input  logic [IDX_W-1:0]      wr0_index,
  input  logic [FLAG_WIDTH-1:0] wr0_flags,
  input  logic [FLAG_WIDTH-1:0] wr0_mask,
  input  logic                  wr1_en,
  input  logic [IDX_W-1:0]      wr1_index,
  input  logic [FLAG_WIDTH-1:0] wr1_flags,
  input  logic [FLAG_WIDTH-1:0] wr1_mask,
  input  logic                  read_clk_en,
  input  logic [IDX_W-1:0]      read_index,
  input  logic [COND_WIDTH-1:0] read_cond,
  output flags_u                read_flags,
  output logic                  read_written,
  output logic                  read_cond_true
);

  logic [ENTRIES-1:0][FLAG_WIDTH-1:0] cell_wdata;
  logic [ENTRIES-1:0][FLAG_WIDTH-1:0] cell_wmask;
  flags_u [ENTRIES-1:0]               cell_flags;
  logic [ENTRIES-1:0]                 cell_written;

  flag_write_decode #(.ENTRIES(ENTRIES)) i_write_decode (
    .wr0_en     (wr0_en),
    .wr0_index  (wr0_index),
    .wr0_flags  (wr0_flags),
    .wr0_mask   (wr0_mask),
    .wr1_en     (wr1_en),
    .wr1_index  (wr1_index),
    .wr1_flags  (wr1_flags),
    .wr1_mask   (wr1_mask),
    .cell_wdata (cell_wdata),
    .cell_wmask (cell_wmask)
  );

  for (genvar e = 0; e < ENTRIES; e++)
  begin : g_cell
    flag_cell i_cell (
      .clk     (clk),
      .rst     (rst),
      .wdata   (cell_wdata[e]),
      .wmask   (cell_wmask[e]),
      .flags   (cell_flags[e]),
      .written (cell_written[e])
    );
  end

  flag_read_port #(.ENTRIES(ENTRIES)) i_read_port (
    .clk            (clk),
    .rst            (rst),
    .read_clk_en    (read_clk_en),
    .read_index     (read_index),
    .read_cond      (read_cond),
    .cell_flags     (cell_flags),
    .cell_written   (cell_written),
    .read_flags     (read_flags),
    .read_written   (read_written),
    .read_cond_true (read_cond_true)
  );

endmodule

`default_nettype wire

/* include/flag_model.svh */
`ifndef FLAG_MODEL_SVH
`define FLAG_MODEL_SVH

// Relies on flag_pkg being imported by the including module

localparam int MODEL_ENTRIES = 8;
localparam int MODEL_IDX_W = $clog2(MODEL_ENTRIES);

logic [FLAG_WIDTH-1:0] model_flags [MODEL_ENTRIES];  // Mirror of the cell contents
logic                  model_written [MODEL_ENTRIES];

function automatic void model_reset();
  for (int i = 0; i < MODEL_ENTRIES; i++)
  begin
    model_flags[i]   = '0;
    model_written[i] = 1'b0;
  end
endfunction

function automatic logic [FLAG_WIDTH-1:0] model_merge(
  input logic [FLAG_WIDTH-1:0] old_flags,
  input logic [FLAG_WIDTH-1:0] data,
  input logic [FLAG_WIDTH-1:0] mask
);
  logic [FLAG_WIDTH-1:0] merged;
  for (int b = 0; b < FLAG_WIDTH; b++)
  begin
    merged[b] = mask[b] ? data[b] : old_flags[b];  // Only a masked flag takes the new value
  end
  return merged;
endfunction

// Applying port 1 last gives it the win on shared flags
function automatic void model_write(
  input logic                   en0,
  input logic [MODEL_IDX_W-1:0] idx0,
  input logic [FLAG_WIDTH-1:0]  flags0,
  input logic [FLAG_WIDTH-1:0]  mask0,
  input logic                   en1,
  input logic [MODEL_IDX_W-1:0] idx1,
  input logic [FLAG_WIDTH-1:0]  flags1,
  input logic [FLAG_WIDTH-1:0]  mask1
);
  if (en0)
  begin
    model_flags[idx0]   = model_merge(model_flags[idx0], flags0, mask0);
    model_written[idx0] = model_written[idx0] | (|mask0);
  end
  if (en1)
  begin
    model_flags[idx1]   = model_merge(model_flags[idx1], flags1, mask1);
    model_written[idx1] = model_written[idx1] | (|mask1);
  end
endfunction

function automatic logic model_cond(
  input logic [FLAG_WIDTH-1:0] flags,
  input logic [COND_WIDTH-1:0] cond
);
  logic base;
  logic sign_ne;
  sign_ne = flags[SF_BIT] ^ flags[OF_BIT];
  case ({cond[COND_WIDTH-1:1], 1'b0})
    COND_O:  base = flags[OF_BIT];
    COND_B:  base = flags[CF_BIT];
    COND_E:  base = flags[ZF_BIT];
    COND_BE: base = flags[CF_BIT] | flags[ZF_BIT];
    COND_S:  base = flags[SF_BIT];
    COND_P:  base = flags[PF_BIT];
    COND_L:  base = sign_ne;
    default: base = flags[ZF_BIT] | sign_ne;
  endcase
  return base ^ cond[0];  // Odd codes invert
endfunction

`endif

/* bench/flag_file_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module flag_file_tb
  import flag_pkg::*;
;

  `include "flag_model.svh"

  localparam int ENTRIES      = 8;
  localparam int IDX_W        = $clog2(ENTRIES);
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;

  // Cycles spent by reset and by each test in the order they run
  localparam int TEST_CYCLES = RESET_CYCLES + 8 + 32 + 32 + 16 + 68 + 8;
  localparam int WATCHDOG_NS = (TEST_CYCLES * 3 / 2 + 20) * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  logic                  wr0_en;
  logic [IDX_W-1:0]      wr0_index;
  logic [FLAG_WIDTH-1:0] wr0_flags;
  logic [FLAG_WIDTH-1:0] wr0_mask;
  logic                  wr1_en;
  logic [IDX_W-1:0]      wr1_index;
  logic [FLAG_WIDTH-1:0] wr1_flags;
  logic [FLAG_WIDTH-1:0] wr1_mask;
  logic                  read_clk_en;
  logic [IDX_W-1:0]      read_index;
  logic [COND_WIDTH-1:0] read_cond;
  flags_u                read_flags;
  logic                  read_written;
  logic                  read_cond_true;

  logic [31:0] lfsr_state;
  int          checks_total;
  int          errors_total;
  int          checks_at_start;
  int          errors_at_start;

  flag_file #(.ENTRIES(ENTRIES)) i_flag_file (
    .clk            (clk),
    .rst            (rst),
    .wr0_en         (wr0_en),
    .wr0_index      (wr0_index),
    .wr0_flags      (wr0_flags),
    .wr0_mask       (wr0_mask),
    .wr1_en         (wr1_en),
    .wr1_index      (wr1_index),
    .wr1_flags      (wr1_flags),
    .wr1_mask       (wr1_mask),
    .read_clk_en    (read_clk_en),
    .read_index     (read_index),
    .read_cond      (read_cond),
    .read_flags     (read_flags),
    .read_written   (read_written),
    .read_cond_true (read_cond_true)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Right-shifting Galois form with taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hD000_0001) : (state >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      value      = {value[30:0], lfsr_state[0]};  // One LFSR step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;  // Inputs change and outputs are sampled well clear of the edge
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    checks_total++;
    assert (got === expected)
    else
    begin
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
      errors_total++;
    end
  endtask

  task automatic begin_test();
    checks_at_start = checks_total;
    errors_at_start = errors_total;
  endtask

  task automatic end_test(input string name);
    $display("%-20s %0d checks, %0d errors", name, checks_total - checks_at_start,
             errors_total - errors_at_start);
  endtask

  // Drives both write ports for one edge and mirrors the write in the model
  task automatic write_ports(
    input logic en0, input logic [IDX_W-1:0] idx0,
    input logic [FLAG_WIDTH-1:0] f0, input logic [FLAG_WIDTH-1:0] m0,
    input logic en1, input logic [IDX_W-1:0] idx1,
    input logic [FLAG_WIDTH-1:0] f1, input logic [FLAG_WIDTH-1:0] m1
  );
    wr0_en    = en0;
    wr0_index = idx0;
    wr0_flags = f0;
    wr0_mask  = m0;
    wr1_en    = en1;
    wr1_index = idx1;
    wr1_flags = f1;
    wr1_mask  = m1;
    model_write(en0, idx0, f0, m0, en1, idx1, f1, m1);
    tick();
    wr0_en = 1'b0;
    wr1_en = 1'b0;
  endtask

  task automatic read_entry(input logic [IDX_W-1:0] idx, input logic [COND_WIDTH-1:0] cond);
    read_clk_en = 1'b1;
    read_index  = idx;
    read_cond   = cond;
    tick();  // Outputs follow the captured index from this edge on
    read_clk_en = 1'b0;
  endtask

  task automatic compare_entry(input logic [IDX_W-1:0] idx);
    compare_value($sformatf("read_flags[%0d]", idx), 32'(read_flags.raw),
                  32'(model_flags[idx]));
    compare_value($sformatf("read_written[%0d]", idx), 32'(read_written),
                  32'(model_written[idx]));
  endtask

  task automatic check_reset_state();
    begin_test();
    for (int i = 0; i < ENTRIES; i++)
    begin
      read_entry(IDX_W'(i), COND_O);
      compare_value($sformatf("read_flags[%0d]", i), 32'(read_flags.raw), 32'h0);
      compare_value($sformatf("read_written[%0d]", i), 32'(read_written), 32'h0);
      compare_value("read_cond_true", 32'(read_cond_true), 32'h0);  // OF clear
    end
    end_test("reset state");
  endtask

  task automatic full_write_readback();
    logic [FLAG_WIDTH-1:0] data;
    begin_test();
    for (int i = 0; i < ENTRIES; i++)
    begin
      data = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
      write_ports(1'b1, IDX_W'(i), data, '1, 1'b0, '0, '0, '0);
      read_entry(IDX_W'(i), COND_O);
      compare_value("read_flags port 0", 32'(read_flags.raw), 32'(data));
      compare_value("read_written", 32'(read_written), 32'h1);
      data = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
      write_ports(1'b0, '0, '0, '0, 1'b1, IDX_W'(i), data, '1);
      read_entry(IDX_W'(i), COND_O);
      compare_value("read_flags port 1", 32'(read_flags.raw), 32'(data));
      compare_entry(IDX_W'(i));
    end
    end_test("full writes");
  endtask

  task automatic masked_update();
    logic [IDX_W-1:0]      idx;
    logic [FLAG_WIDTH-1:0] data;
    logic [FLAG_WIDTH-1:0] mask;
    logic [FLAG_WIDTH-1:0] old_flags;
    logic                  use_port1;
    begin_test();
    for (int n = 0; n < 16; n++)
    begin
      idx       = IDX_W'(random_bits(IDX_W));
      data      = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
      mask      = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
      use_port1 = random_bits(1) != 0;
      old_flags = model_flags[idx];
      if (use_port1)
        write_ports(1'b0, '0, '0, '0, 1'b1, idx, data, mask);
      else
        write_ports(1'b1, idx, data, mask, 1'b0, '0, '0, '0);
      read_entry(idx, COND_O);
      compare_value("read_flags unmasked", 32'(read_flags.raw & ~mask),
                    32'(old_flags & ~mask));  // Flags outside the mask stay put
      compare_entry(idx);
    end
    end_test("masked writes");
  endtask

  task automatic port_collision();
    logic [IDX_W-1:0]      idx;
    logic [FLAG_WIDTH-1:0] f0;
    logic [FLAG_WIDTH-1:0] f1;
    logic [FLAG_WIDTH-1:0] m0;
    logic [FLAG_WIDTH-1:0] m1;
    logic [FLAG_WIDTH-1:0] shared;
    begin_test();
    for (int n = 0; n < 8; n++)
    begin
      idx    = IDX_W'(random_bits(IDX_W));
      f0     = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
      f1     = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
      shared = FLAG_WIDTH'(1) << (random_bits(3) % FLAG_WIDTH);  // Forces an overlap
      f1     = f1 ^ (~(f0 ^ f1) & shared);  // The ports disagree on the shared flag
      m0     = FLAG_WIDTH'(random_bits(FLAG_WIDTH)) | shared;
      m1     = FLAG_WIDTH'(random_bits(FLAG_WIDTH)) | shared;
      write_ports(1'b1, idx, f0, m0, 1'b1, idx, f1, m1);
      read_entry(idx, COND_O);
      compare_value("read_flags port 1 bits", 32'(read_flags.raw & m1), 32'(f1 & m1));
      compare_value("read_flags port 0 bits", 32'(read_flags.raw & m0 & ~m1),
                    32'(f0 & m0 & ~m1));
      compare_entry(idx);
    end
    end_test("collisions");
  endtask

  task automatic condition_sweep();
    logic [FLAG_WIDTH-1:0] data;
    begin_test();
    for (int n = 0; n < 4; n++)
    begin
      data = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
      write_ports(1'b1, IDX_W'(5), data, '1, 1'b0, '0, '0, '0);
      for (int c = 0; c < 16; c++)
      begin
        read_entry(IDX_W'(5), COND_WIDTH'(c));
        compare_value($sformatf("read_cond_true cond %0d flags 0x%0h", c, data),
                      32'(read_cond_true), 32'(model_cond(data, COND_WIDTH'(c))));
      end
    end
    end_test("conditions");
  endtask

  task automatic read_hold_tracking();
    logic [FLAG_WIDTH-1:0] data;
    begin_test();
    data = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
    write_ports(1'b1, IDX_W'(2), data, '1, 1'b1, IDX_W'(3), ~data, '1);
    read_entry(IDX_W'(2), COND_E);
    for (int k = 1; k <= 4; k++)
    begin
      read_index = IDX_W'(k + 2);  // Moves without read_clk_en, so nothing is captured
      read_cond  = COND_WIDTH'(k);
      tick();
      compare_value("read_flags held", 32'(read_flags.raw), 32'(model_flags[2]));
      compare_value("read_cond_true held", 32'(read_cond_true),
                    32'(model_cond(model_flags[2], COND_E)));
    end
    write_ports(1'b1, IDX_W'(2), ~model_flags[2], '1, 1'b0, '0, '0, '0);
    compare_value("read_flags tracked", 32'(read_flags.raw), 32'(model_flags[2]));
    read_clk_en = 1'b1;  // Capture and write land on the same edge
    read_index  = IDX_W'(6);
    data        = FLAG_WIDTH'(random_bits(FLAG_WIDTH));
    write_ports(1'b0, '0, '0, '0, 1'b1, IDX_W'(6), data, '1);
    read_clk_en = 1'b0;
    compare_value("read_flags same edge", 32'(read_flags.raw), 32'(data));
    compare_entry(IDX_W'(6));
    end_test("hold and tracking");
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    rst          = 1'b1;
    wr0_en       = 1'b0;
    wr0_index    = '0;
    wr0_flags    = '0;
    wr0_mask     = '0;
    wr1_en       = 1'b0;
    wr1_index    = '0;
    wr1_flags    = '0;
    wr1_mask     = '0;
    read_clk_en  = 1'b0;
    read_index   = '0;
    read_cond    = COND_O;
    lfsr_state   = 32'd79079;
    checks_total = 0;
    errors_total = 0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    check_reset_state();
    full_write_readback();
    masked_update();
    port_collision();
    condition_sweep();
    read_hold_tracking();

    $display("Summary: %0d checks passed, %0d checks failed",
             checks_total - errors_total, errors_total);
    if (errors_total == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
logic/flag_pkg.sv
logic/flag_write_decode.sv
logic/flag_cell.sv
logic/flag_read_port.sv
logic/flag_file.sv
bench/flag_file_tb.sv

/* Makefile */
# Verilator simulation of the flag retirement register file

VERILATOR ?= verilator
TOP       ?= flag_file_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Verification passed

.PHONY: sim clean

# The run passes only when the pass message appears on a line of its own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
